// File: spi_reg_bridge.f
hdl/spi_reg_pkg.sv
hdl/spi_sync.sv
hdl/spi_shifter.sv
hdl/spi_cmd_fsm.sv
hdl/spi_reg_bridge.sv
tb/spi_reg_bridge_assertions.sv
tb/tb_spi_reg_bridge.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spi_reg_bridge -f spi_reg_bridge.f \
  || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vtb_spi_reg_bridge)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '*** PASSED ***' && exit 0 || exit 1

// File: tb/tb_spi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_reg_bridge
  import spi_reg_pkg::*;
();

  localparam int ADDR_W    = 7;
  localparam int CLK_HALF  = 50;
  localparam int HALF_SCLK = 8;
  localparam int MAX_STALL = 2;
  localparam int DRIVE_DLY = 1;
  localparam int BUS_WAIT  = 300;

  logic              clk;
  logic              rst_n;
  logic              sclk;
  logic              mosi;
  logic              ss;
  logic              miso;
  logic              req_valid;
  logic              req_write;
  logic [ADDR_W-1:0] req_addr;
  spi_byte_t         req_wdata;
  logic              req_ready;
  spi_byte_t         req_rdata;
  logic              clr_err;
  logic              err_polarity;
  logic              err_overrun;

  integer            seed = 32'hee1ad261;
  int                errors;
  int                checks;
  int                timeouts;
  int                stall_cnt;
  logic              hold_ready;
  logic [7:0]        mem [0:127];
  logic [7:0]        pool [0:15];
  logic [7:0]        tx_buf [0:15];
  logic [7:0]        rx_buf [0:15];
  logic              log_write [$];
  logic [ADDR_W-1:0] log_addr [$];
  logic [7:0]        log_data [$];

  spi_reg_bridge #(
    .ADDR_W      (ADDR_W),
    .SYNC_STAGES (2)
  ) u_spi_reg_bridge (
    .clk          (clk),
    .rst_n        (rst_n),
    .sclk         (sclk),
    .mosi         (mosi),
    .ss           (ss),
    .miso         (miso),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .req_ready    (req_ready),
    .req_rdata    (req_rdata),
    .clr_err      (clr_err),
    .err_polarity (err_polarity),
    .err_overrun  (err_overrun)
  );

  always #CLK_HALF clk = ~clk;

  // ******************************
  // register memory model
  // ******************************
  assign req_rdata = mem[req_addr];

  // log each transfer on the falling edge before the edge that takes it
  always @(negedge clk) begin
    if (rst_n && req_valid && req_ready) begin
      log_write.push_back(req_write);
      log_addr.push_back(req_addr);
      if (req_write) begin
        log_data.push_back(req_wdata);
        mem[req_addr] = req_wdata;
      end else begin
        log_data.push_back(mem[req_addr]);
      end
    end
  end

  // random back-pressure, never more than MAX_STALL low cycles in a row
  always @(posedge clk) begin
    logic [31:0] rnd;
    #DRIVE_DLY;
    rnd = $random(seed);
    if (hold_ready)
      req_ready = 1'b0;
    else if (stall_cnt >= MAX_STALL)
      req_ready = 1'b1;
    else
      req_ready = rnd[0];
    stall_cnt = req_ready ? 0 : stall_cnt + 1;
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  // ******************************
  // spi master, mode 0, msb first
  // ******************************
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      sclk = 1'b0;
      mosi = tx[i];
      wait_cycles(HALF_SCLK);
      rx[i] = miso;
      sclk = 1'b1;
      wait_cycles(HALF_SCLK);
    end
  endtask

  // sclk level at the ss fall decides the polarity
  task automatic run_frame(input logic [7:0] cmd, input int n, input logic sclk_idle);
    logic [7:0] cmd_rx;
    sclk = sclk_idle;
    wait_cycles(HALF_SCLK);
    ss = 1'b0;
    wait_cycles(HALF_SCLK);
    spi_byte(cmd, cmd_rx);
    for (int i = 0; i < n; i++)
      spi_byte(tx_buf[i], rx_buf[i]);
    ss = 1'b1;
    wait_cycles(2 * HALF_SCLK);
  endtask

  task automatic wait_bus_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (req_valid && n < BUS_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (req_valid) begin
      $display("timeout: register request still pending after %0d cycles", BUS_WAIT);
      timeouts++;
    end
    wait_cycles(2);
  endtask

  task automatic pulse_clr_err();
    clr_err = 1'b1;
    wait_cycles(1);
    clr_err = 1'b0;
    wait_cycles(2);
  endtask

  task automatic clear_log();
    log_write.delete();
    log_addr.delete();
    log_data.delete();
  endtask

  // compare logged transfers against expected addresses and data
  task automatic check_log(input logic is_write, input logic [ADDR_W-1:0] base, input int n);
    check_value("transfer count", 32'(log_addr.size()), 32'(n));
    for (int i = 0; i < n && i < log_addr.size(); i++) begin
      check_value("req_write", 32'(log_write[i]), 32'(is_write));
      check_value("req_addr", 32'(log_addr[i]), 32'(ADDR_W'(base + i)));
      if (is_write)
        check_value("req_wdata", 32'(log_data[i]), 32'(tx_buf[i]));
    end
  endtask

  initial begin
    logic [31:0]       rnd;
    logic [ADDR_W-1:0] base;
    logic [7:0]        old_a;
    logic [7:0]        old_b;
    clk        = 1'b0;
    rst_n      = 1'b0;
    sclk       = 1'b1;
    mosi       = 1'b1;
    ss         = 1'b1;
    req_ready  = 1'b0;
    clr_err    = 1'b0;
    hold_ready = 1'b0;
    stall_cnt  = 0;
    errors     = 0;
    checks     = 0;
    timeouts   = 0;
    for (int i = 0; i < 128; i++)
      mem[i] = 8'(i * 3) ^ 8'h5a;
    for (int i = 0; i < 16; i++) begin
      rnd = $random(seed);
      pool[i] = rnd[7:0];
    end
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    wait_cycles(4);

    // idle outputs after reset
    check_value("req_valid", 32'(req_valid), 32'd0);
    check_value("err_polarity", 32'(err_polarity), 32'd0);
    check_value("err_overrun", 32'(err_overrun), 32'd0);
    check_value("miso", 32'(miso), 32'd1);

    // write burst wrapping past the top address
    base = 7'h7e;
    for (int i = 0; i < 4; i++)
      tx_buf[i] = pool[i];
    clear_log();
    run_frame({1'b0, base}, 4, 1'b1);
    wait_bus_idle();
    check_log(1'b1, base, 4);

    // read burst, N data bytes give N+1 fetches
    base = 7'h7d;
    for (int i = 0; i < 3; i++)
      tx_buf[i] = 8'hff;
    clear_log();
    run_frame({1'b1, base}, 3, 1'b1);
    wait_bus_idle();
    check_log(1'b0, base, 4);
    for (int i = 0; i < 3; i++)
      check_value("miso byte", 32'(rx_buf[i]), 32'(mem[ADDR_W'(base + i)]));

    // frame starting with sclk low is ignored
    base = 7'h10;
    tx_buf[0] = pool[4];
    tx_buf[1] = pool[5];
    clear_log();
    run_frame({1'b0, base}, 2, 1'b0);
    wait_bus_idle();
    check_value("err_polarity", 32'(err_polarity), 32'd1);
    check_value("transfer count", 32'(log_addr.size()), 32'd0);
    pulse_clr_err();
    check_value("err_polarity", 32'(err_polarity), 32'd0);
    tx_buf[0] = pool[6];
    run_frame({1'b0, base}, 1, 1'b1);
    wait_bus_idle();
    check_log(1'b1, base, 1);

    // stalled bus during a write burst
    base = 7'h20;
    old_a = mem[7'h21];
    old_b = mem[7'h22];
    for (int i = 0; i < 3; i++)
      tx_buf[i] = pool[8 + i];
    hold_ready = 1'b1;
    clear_log();
    run_frame({1'b0, base}, 3, 1'b1);
    check_value("err_overrun", 32'(err_overrun), 32'd1);
    hold_ready = 1'b0;
    wait_bus_idle();
    check_log(1'b1, base, 1);
    check_value("mem[21]", 32'(mem[7'h21]), 32'(old_a));
    check_value("mem[22]", 32'(mem[7'h22]), 32'(old_b));
    pulse_clr_err();
    check_value("err_overrun", 32'(err_overrun), 32'd0);

    wait_cycles(4);
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, u_spi_reg_bridge.u_assertions.fail_cnt);
    if (errors == 0 && timeouts == 0 && u_spi_reg_bridge.u_assertions.fail_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/spi_reg_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge_assertions
  import spi_reg_pkg::*;
#(
  parameter int ADDR_W = 7
) (
  input logic              clk,
  input logic              rst_n,
  input logic              req_valid,
  input logic              req_ready,
  input logic              req_write,
  input logic [ADDR_W-1:0] req_addr,
  input spi_byte_t         req_wdata,
  input logic              clr_err,
  input logic              err_polarity,
  input logic              err_overrun
);

  int fail_cnt = 0;

  // ******************************
  // register bus handshake
  // ******************************
  valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid)
    else begin
      $error("req_valid dropped before its transfer");
      fail_cnt++;
    end

  payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> $stable(req_write) && $stable(req_addr) && $stable(req_wdata))
    else begin
      $error("request payload changed while stalled");
      fail_cnt++;
    end

  // a masked frame never reaches the bus
  no_req_on_bad_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req_valid) |-> !err_polarity)
    else begin
      $error("request started with err_polarity set");
      fail_cnt++;
    end

  // ******************************
  // sticky error flags
  // ******************************
  polarity_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(err_polarity) |-> $past(clr_err))
    else begin
      $error("err_polarity cleared without clr_err");
      fail_cnt++;
    end

  overrun_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(err_overrun) |-> $past(clr_err))
    else begin
      $error("err_overrun cleared without clr_err");
      fail_cnt++;
    end

endmodule

bind spi_reg_bridge spi_reg_bridge_assertions #(
  .ADDR_W(ADDR_W)
) u_assertions (.*);

`default_nettype wire

// File: hdl/spi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge
  import spi_reg_pkg::*;
#(
  parameter int ADDR_W      = 7,
  parameter int SYNC_STAGES = 2
) (
  input  logic              clk,
  input  logic              rst_n,
  // spi pins
  input  logic              sclk,
  input  logic              mosi,
  input  logic              ss,
  output logic              miso,
  // register bus
  output logic              req_valid,
  output logic              req_write,
  output logic [ADDR_W-1:0] req_addr,
  output spi_byte_t         req_wdata,
  input  logic              req_ready,
  input  spi_byte_t         req_rdata,
  // sticky errors
  input  logic              clr_err,
  output logic              err_polarity,
  output logic              err_overrun
);

  logic      mosi_s;
  logic      sclk_rise;
  logic      sclk_fall;
  logic      frame_start;
  logic      frame_active;
  spi_byte_t rx_byte;
  logic      byte_done;
  logic      tx_load;
  spi_byte_t tx_byte;

  // ******************************
  // synchronizer, shifter, fsm
  // ******************************
  spi_sync #(
    .SYNC_STAGES(SYNC_STAGES)
  ) u_sync (
    .clk          (clk),
    .rst_n        (rst_n),
    .sclk         (sclk),
    .mosi         (mosi),
    .ss           (ss),
    .clr_err      (clr_err),
    .mosi_s       (mosi_s),
    .sclk_rise    (sclk_rise),
    .sclk_fall    (sclk_fall),
    .frame_start  (frame_start),
    .frame_active (frame_active),
    .err_polarity (err_polarity)
  );

  spi_shifter u_shifter (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_active (frame_active),
    .frame_start  (frame_start),
    .sclk_rise    (sclk_rise),
    .sclk_fall    (sclk_fall),
    .mosi_s       (mosi_s),
    .tx_load      (tx_load),
    .tx_byte      (tx_byte),
    .rx_byte      (rx_byte),
    .byte_done    (byte_done),
    .miso         (miso)
  );

  spi_cmd_fsm #(
    .ADDR_W(ADDR_W)
  ) u_cmd_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .frame_active (frame_active),
    .frame_start  (frame_start),
    .rx_byte      (rx_byte),
    .byte_done    (byte_done),
    .req_ready    (req_ready),
    .req_rdata    (req_rdata),
    .clr_err      (clr_err),
    .tx_load      (tx_load),
    .tx_byte      (tx_byte),
    .req_valid    (req_valid),
    .req_write    (req_write),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .err_overrun  (err_overrun)
  );

endmodule

`default_nettype wire

// File: hdl/spi_cmd_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_fsm
  import spi_reg_pkg::*;
#(
  parameter int ADDR_W = 7
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              frame_active,
  input  logic              frame_start,
  input  spi_byte_t         rx_byte,
  input  logic              byte_done,
  input  logic              req_ready,
  input  spi_byte_t         req_rdata,
  input  logic              clr_err,
  output logic              tx_load,
  output spi_byte_t         tx_byte,
  output logic              req_valid,
  output logic              req_write,
  output logic [ADDR_W-1:0] req_addr,
  output spi_byte_t         req_wdata,
  output logic              err_overrun
);

  cmd_state_e        state;
  cmd_state_e        state_next;
  logic [ADDR_W-1:0] addr;
  logic [ADDR_W-1:0] issue_addr;
  logic              xfer;
  logic              bus_free;
  logic              cmd_done;
  logic              cmd_read;
  logic              wr_byte;
  logic              wr_issue;
  logic              rd_issue;
  logic              rd_xfer;

  assign xfer     = req_valid & req_ready;
  // bus can take a new request next cycle
  assign bus_free = ~req_valid | req_ready;
  assign cmd_done = (state == CMD) & byte_done;
  assign cmd_read = rx_byte[CMD_READ_BIT];
  assign wr_byte  = (state == WR_DATA) & byte_done;
  assign wr_issue = wr_byte & bus_free;

  // prefetch after the command or a data byte; late issue if a write was still pending
  assign rd_issue = (((cmd_done & cmd_read) | ((state == RD_DATA) & byte_done)) & bus_free)
                  | ((state == RD_FETCH) & frame_active & ~req_valid);
  assign rd_xfer  = (state == RD_FETCH) & xfer & ~req_write;

  // command byte carries the start address
  assign issue_addr = cmd_done ? rx_byte[ADDR_W-1:0] : addr;

  // ******************************
  // next state
  // ******************************
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (frame_start)
          state_next = CMD;
      end
      CMD: begin
        if (!frame_active)
          state_next = IDLE;
        else if (byte_done)
          state_next = cmd_read ? RD_FETCH : WR_DATA;
      end
      WR_DATA: begin
        if (!frame_active)
          state_next = IDLE;
      end
      RD_FETCH: begin
        if (rd_xfer)
          state_next = frame_active ? RD_DATA : IDLE;
        else if (!frame_active && !req_valid)
          state_next = IDLE;
      end
      RD_DATA: begin
        if (!frame_active)
          state_next = IDLE;
        else if (byte_done)
          state_next = RD_FETCH;
      end
      default: state_next = IDLE;
    endcase
  end

  // ******************************
  // control registers
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      addr        <= '0;
      req_valid   <= 1'b0;
      tx_load     <= 1'b0;
      err_overrun <= 1'b0;
    end else begin
      state   <= state_next;
      tx_load <= rd_xfer;
      if (wr_issue || rd_issue)
        req_valid <= 1'b1;
      else if (xfer)
        req_valid <= 1'b0;
      // dropped write bytes still advance the address
      if (cmd_done)
        addr <= rx_byte[ADDR_W-1:0];
      else if (wr_byte || rd_xfer)
        addr <= addr + 1'b1;
      if (wr_byte && !bus_free)
        err_overrun <= 1'b1;
      else if (clr_err)
        err_overrun <= 1'b0;
    end
  end

  // request payload and read data
  always_ff @(posedge clk) begin
    if (wr_issue || rd_issue) begin
      req_write <= wr_issue;
      req_addr  <= issue_addr;
    end
    if (wr_issue)
      req_wdata <= rx_byte;
    if (rd_xfer)
      tx_byte <= req_rdata;
  end

endmodule

`default_nettype wire

// File: hdl/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter
  import spi_reg_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      frame_active,
  input  logic      frame_start,
  input  logic      sclk_rise,
  input  logic      sclk_fall,
  input  logic      mosi_s,
  input  logic      tx_load,
  input  spi_byte_t tx_byte,
  output spi_byte_t rx_byte,
  output logic      byte_done,
  output logic      miso
);

  localparam int CNT_W = $clog2(SPI_BYTE_W);

  logic [CNT_W-1:0] bit_cnt;
  logic             last_bit;
  spi_byte_t        rx_shift;
  spi_byte_t        rx_next;
  spi_byte_t        tx_shift;

  assign last_bit = (bit_cnt == CNT_W'(SPI_BYTE_W - 1));
  assign rx_next  = {rx_shift[SPI_BYTE_W-2:0], mosi_s};

  // ******************************
  // receive side
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
    end else begin
      byte_done <= sclk_rise & last_bit;
      if (frame_start)
        bit_cnt <= '0;
      else if (sclk_rise)
        bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
    end
  end

  // sample mosi on the rising edge, msb first
  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      rx_shift <= rx_next;
      if (last_bit)
        rx_byte <= rx_next;
    end
  end

  // ******************************
  // transmit side
  // ******************************
  // The falling edge after the eighth rise of a byte must not shift:
  // by then the prefetched byte is already loaded with its msb on miso.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_shift <= '1;
    end else if (tx_load) begin
      tx_shift <= tx_byte;
    end else if (frame_start) begin
      tx_shift <= '1;
    end else if (sclk_fall && bit_cnt != '0) begin
      tx_shift <= {tx_shift[SPI_BYTE_W-2:0], 1'b1};
    end
  end

  // idle high outside a frame
  assign miso = frame_active ? tx_shift[SPI_BYTE_W-1] : 1'b1;

endmodule

`default_nettype wire

// File: hdl/spi_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic mosi,
  input  logic ss,
  input  logic clr_err,
  output logic mosi_s,
  output logic sclk_rise,
  output logic sclk_fall,
  output logic frame_start,
  output logic frame_active,
  output logic err_polarity
);

  logic [SYNC_STAGES-1:0] sclk_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic [SYNC_STAGES-1:0] ss_sync;
  logic                   sclk_s;
  logic                   ss_s;
  logic                   sclk_d;
  logic                   ss_d;
  logic                   ss_fall;
  logic                   good_next;

  // ******************************
  // input synchronizers
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= '0;
      mosi_sync <= '1;
      ss_sync   <= '1;
      sclk_d    <= 1'b0;
      ss_d      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
      ss_sync   <= {ss_sync[SYNC_STAGES-2:0], ss};
      sclk_d    <= sclk_s;
      ss_d      <= ss_s;
    end
  end

  assign sclk_s = sclk_sync[SYNC_STAGES-1];
  assign ss_s   = ss_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];

  assign ss_fall = ss_d & ~ss_s;
  // sclk must be high when ss falls, otherwise the whole frame is masked
  assign good_next = ~ss_s & (ss_fall ? sclk_s : frame_active);

  // ******************************
  // edge pulses and frame state
  // ******************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      frame_active <= 1'b0;
      frame_start  <= 1'b0;
      sclk_rise    <= 1'b0;
      sclk_fall    <= 1'b0;
      err_polarity <= 1'b0;
    end else begin
      frame_active <= good_next;
      frame_start  <= ss_fall & sclk_s;
      sclk_rise    <= good_next & sclk_s & ~sclk_d;
      sclk_fall    <= good_next & ~sclk_s & sclk_d;
      // sticky until clr_err
      if (ss_fall && !sclk_s)
        err_polarity <= 1'b1;
      else if (clr_err)
        err_polarity <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_reg_pkg.sv
`default_nettype none

package spi_reg_pkg;

  // one spi byte, shifted msb first
  localparam int SPI_BYTE_W = 8;

  typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

  // read flag in the command byte
  localparam int CMD_READ_BIT = 7;

  // ******************************
  // command fsm states
  // ******************************
  typedef enum logic [2:0] {
    IDLE     = 3'd0,  // no frame
    CMD      = 3'd1,  // waiting for command byte
    WR_DATA  = 3'd2,  // write frame
    RD_FETCH = 3'd3,  // read request pending
    RD_DATA  = 3'd4   // read byte going out on miso
  } cmd_state_e;

endpackage

`default_nettype wire
